//--- design/issue_macros.svh
// ----------------------------------------------------------
// Issue stage sizing: scoreboard depth, ID, data and
// register file widths
// ----------------------------------------------------------
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// Scoreboard slots, also the in-flight limit
`define ISSUE_NR_SB_ENTRIES 4

// Transaction ID indexes a scoreboard slot directly
`define ISSUE_TRANS_ID_BITS 2

// Integer datapath width
`define ISSUE_XLEN 32

// Architectural registers, x0 included
`define ISSUE_NR_REGS 32

// Register address width, fixed by the ISA
`define ISSUE_REG_ADDR_BITS 5

`endif

//--- design/issue_pkg.sv
// ----------------------------------------------------------
// Issue stage types shared by the RTL and the testbench
// ----------------------------------------------------------
`include "issue_macros.svh"

package issue_pkg;

  // Execute unit operation
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_AND = 2'd3
  } fu_op_e;

  // Instruction as delivered by decode
  typedef struct packed {
    fu_op_e                           op;
    logic [`ISSUE_REG_ADDR_BITS-1:0]  rd;
    logic [`ISSUE_REG_ADDR_BITS-1:0]  rs1;
    logic [`ISSUE_REG_ADDR_BITS-1:0]  rs2;
  } decoded_instr_t;

  // Dispatch payload, operands already resolved
  typedef struct packed {
    fu_op_e                           op;
    logic [`ISSUE_XLEN-1:0]           operand_a;
    logic [`ISSUE_XLEN-1:0]           operand_b;
    logic [`ISSUE_TRANS_ID_BITS-1:0]  trans_id;
  } fu_data_t;

  // Result returned by the execute unit
  typedef struct packed {
    logic [`ISSUE_TRANS_ID_BITS-1:0]  trans_id;
    logic [`ISSUE_XLEN-1:0]           data;
  } writeback_t;

  // Retired result, in program order
  typedef struct packed {
    logic [`ISSUE_REG_ADDR_BITS-1:0]  rd;
    logic [`ISSUE_XLEN-1:0]           data;
    logic [`ISSUE_TRANS_ID_BITS-1:0]  trans_id;
  } commit_t;

  // One scoreboard slot
  typedef struct packed {
    decoded_instr_t                   instr;
    logic                             issued;
    logic                             result_valid;
    logic [`ISSUE_XLEN-1:0]           result;
  } sb_entry_t;

  // Scoreboard state seen by the operand reader
  typedef struct packed {
    sb_entry_t [`ISSUE_NR_SB_ENTRIES-1:0] sbe;
    logic [`ISSUE_NR_SB_ENTRIES-1:0]      busy;
    logic [`ISSUE_TRANS_ID_BITS-1:0]      issue_pointer;
  } fwd_t;

endpackage

//--- design/scoreboard.sv
// ----------------------------------------------------------
// Scoreboard: circular instruction buffer tracking each
// instruction from decode through writeback to commit
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "issue_macros.svh"

module scoreboard (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              flush_i,
  // Decode channel
  input  issue_pkg::decoded_instr_t         decode_instr_i,
  input  logic                              decode_valid_i,
  output logic                              decode_ack_o,
  // Oldest unissued instruction
  output issue_pkg::decoded_instr_t         issue_instr_o,
  output logic [`ISSUE_TRANS_ID_BITS-1:0]   issue_id_o,
  output logic                              issue_valid_o,
  input  logic                              issue_ack_i,
  // Forwarding view
  output issue_pkg::fwd_t                   fwd_o,
  // Writeback channel, never back-pressured
  input  issue_pkg::writeback_t             wb_i,
  input  logic                              wb_valid_i,
  // Commit channel
  output issue_pkg::commit_t                commit_o,
  output logic                              commit_valid_o,
  input  logic                              commit_ack_i,
  output logic                              sb_full_o
);

  // One extra bit so a full buffer is distinct from an empty one
  typedef logic [`ISSUE_TRANS_ID_BITS:0] cnt_t;

  // Control state per slot
  logic [`ISSUE_NR_SB_ENTRIES-1:0]   busy_q;
  logic [`ISSUE_NR_SB_ENTRIES-1:0]   issued_q;
  logic [`ISSUE_NR_SB_ENTRIES-1:0]   rvalid_q;

  // Payload per slot
  issue_pkg::decoded_instr_t         instr_q [`ISSUE_NR_SB_ENTRIES];
  logic [`ISSUE_XLEN-1:0]            result_q [`ISSUE_NR_SB_ENTRIES];

  logic [`ISSUE_TRANS_ID_BITS-1:0]   alloc_ptr_q;
  logic [`ISSUE_TRANS_ID_BITS-1:0]   issue_ptr_q;
  logic [`ISSUE_TRANS_ID_BITS-1:0]   commit_ptr_q;
  cnt_t                              cnt_q;

  logic alloc_hs;
  logic issue_hs;
  logic commit_hs;
  logic wb_hit;

  // ----------------------------------------------------------
  // Handshakes and status
  // ----------------------------------------------------------
  assign sb_full_o    = (cnt_q == cnt_t'(`ISSUE_NR_SB_ENTRIES));
  assign decode_ack_o = ~sb_full_o & ~flush_i;
  assign alloc_hs     = decode_valid_i & decode_ack_o;

  // In-order issue, so the issue pointer always names the oldest unissued slot
  assign issue_instr_o = instr_q[issue_ptr_q];
  assign issue_id_o    = issue_ptr_q;
  assign issue_valid_o = busy_q[issue_ptr_q] & ~issued_q[issue_ptr_q];
  assign issue_hs      = issue_valid_o & issue_ack_i;

  // Results of flushed instructions are dropped
  assign wb_hit = wb_valid_i & busy_q[wb_i.trans_id] & issued_q[wb_i.trans_id];

  // Head of the buffer retires once its result is back
  assign commit_valid_o   = busy_q[commit_ptr_q] & rvalid_q[commit_ptr_q];
  assign commit_o.rd      = instr_q[commit_ptr_q].rd;
  assign commit_o.data    = result_q[commit_ptr_q];
  assign commit_o.trans_id = commit_ptr_q;
  assign commit_hs        = commit_valid_o & commit_ack_i;

  // Forwarding view, rebuilt from the split arrays
  always_comb begin
    for (int i = 0; i < `ISSUE_NR_SB_ENTRIES; i++) begin
      fwd_o.sbe[i].instr        = instr_q[i];
      fwd_o.sbe[i].issued       = issued_q[i];
      fwd_o.sbe[i].result_valid = rvalid_q[i];
      fwd_o.sbe[i].result       = result_q[i];
    end
    fwd_o.busy          = busy_q;
    fwd_o.issue_pointer = issue_ptr_q;
  end

  // ----------------------------------------------------------
  // Pointers, count and slot flags
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      busy_q       <= '0;
      issued_q     <= '0;
      rvalid_q     <= '0;
      alloc_ptr_q  <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      if (alloc_hs) begin
        busy_q[alloc_ptr_q]   <= 1'b1;
        issued_q[alloc_ptr_q] <= 1'b0;
        rvalid_q[alloc_ptr_q] <= 1'b0;
        alloc_ptr_q           <= alloc_ptr_q + 1'b1;
      end
      if (issue_hs) begin
        issued_q[issue_ptr_q] <= 1'b1;
        issue_ptr_q           <= issue_ptr_q + 1'b1;
      end
      if (wb_hit) begin
        rvalid_q[wb_i.trans_id] <= 1'b1;
      end
      // Never the slot being allocated, since that one is not busy
      if (commit_hs) begin
        busy_q[commit_ptr_q] <= 1'b0;
        commit_ptr_q         <= commit_ptr_q + 1'b1;
      end
      case ({alloc_hs, commit_hs})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Instruction and result storage
  always_ff @(posedge clk_i) begin
    if (alloc_hs) begin
      instr_q[alloc_ptr_q] <= decode_instr_i;
    end
    if (wb_hit) begin
      result_q[wb_i.trans_id] <= wb_i.data;
    end
  end

  // ----------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------
  // Execute unit only answers for instructions that were dispatched
  wb_targets_issued : assert property (@(posedge clk_i) disable iff (reset_i)
    wb_valid_i |-> busy_q[wb_i.trans_id] && issued_q[wb_i.trans_id]);

  count_bounded : assert property (@(posedge clk_i) disable iff (reset_i)
    cnt_q <= cnt_t'(`ISSUE_NR_SB_ENTRIES));

endmodule

//--- design/issue_read_operands.sv
// ----------------------------------------------------------
// Issue and read operands: hazard check, operand select and
// registered dispatch to the execute port
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_read_operands (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              flush_i,
  // From the scoreboard
  input  issue_pkg::decoded_instr_t         issue_instr_i,
  input  logic [`ISSUE_TRANS_ID_BITS-1:0]   issue_id_i,
  input  logic                              issue_valid_i,
  output logic                              issue_ack_o,
  input  issue_pkg::fwd_t                   fwd_i,
  // Register file read ports
  output logic [`ISSUE_REG_ADDR_BITS-1:0]   rs1_addr_o,
  output logic [`ISSUE_REG_ADDR_BITS-1:0]   rs2_addr_o,
  input  logic [`ISSUE_XLEN-1:0]            rs1_data_i,
  input  logic [`ISSUE_XLEN-1:0]            rs2_data_i,
  // Execute port
  output issue_pkg::fu_data_t               fu_data_o,
  output logic                              fu_valid_o,
  input  logic                              fu_ready_i,
  output logic                              stall_issue_o
);

  // Outcome of a producer search for one source register
  typedef struct packed {
    logic                   hit;
    logic                   ready;
    logic [`ISSUE_XLEN-1:0] data;
  } lookup_t;

  lookup_t             rs1_lookup;
  lookup_t             rs2_lookup;
  logic                hazard;
  logic                can_load;
  issue_pkg::fu_data_t fu_data_d;
  issue_pkg::fu_data_t fu_data_q;
  logic                fu_valid_q;

  // ----------------------------------------------------------
  // Producer search
  // ----------------------------------------------------------
  // Walks back from the issuing slot; every older busy slot is already
  // issued and every younger one is not, so issued marks age
  function automatic lookup_t find_producer(
    input issue_pkg::fwd_t                 fwd,
    input logic [`ISSUE_REG_ADDR_BITS-1:0] rs
  );
    lookup_t                         res;
    logic [`ISSUE_TRANS_ID_BITS-1:0] idx;
    res = '0;
    idx = fwd.issue_pointer;
    for (int k = 1; k < `ISSUE_NR_SB_ENTRIES; k++) begin
      idx = idx - 1'b1;
      // First match going back is the youngest older writer
      if (!res.hit && (rs != '0) && fwd.busy[idx] && fwd.sbe[idx].issued &&
          (fwd.sbe[idx].instr.rd == rs)) begin
        res.hit   = 1'b1;
        res.ready = fwd.sbe[idx].result_valid;
        res.data  = fwd.sbe[idx].result;
      end
    end
    return res;
  endfunction

  assign rs1_addr_o = issue_instr_i.rs1;
  assign rs2_addr_o = issue_instr_i.rs2;

  assign rs1_lookup = find_producer(fwd_i, issue_instr_i.rs1);
  assign rs2_lookup = find_producer(fwd_i, issue_instr_i.rs2);

  // Producer found but result not back yet
  assign hazard = (rs1_lookup.hit & ~rs1_lookup.ready) |
                  (rs2_lookup.hit & ~rs2_lookup.ready);

  assign stall_issue_o = issue_valid_i & hazard;

  // ----------------------------------------------------------
  // Dispatch register
  // ----------------------------------------------------------
  // Free when empty or when its content leaves this cycle
  assign can_load    = ~fu_valid_q | fu_ready_i;
  assign issue_ack_o = issue_valid_i & ~hazard & can_load & ~flush_i;

  // Forwarded result wins over the register file
  always_comb begin
    fu_data_d.op        = issue_instr_i.op;
    fu_data_d.operand_a = rs1_lookup.hit ? rs1_lookup.data : rs1_data_i;
    fu_data_d.operand_b = rs2_lookup.hit ? rs2_lookup.data : rs2_data_i;
    fu_data_d.trans_id  = issue_id_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      fu_valid_q <= 1'b0;
    end else if (issue_ack_o) begin
      fu_valid_q <= 1'b1;
    end else if (fu_ready_i) begin
      fu_valid_q <= 1'b0;
    end
  end

  // Payload only moves on an issue handshake
  always_ff @(posedge clk_i) begin
    if (issue_ack_o) begin
      fu_data_q <= fu_data_d;
    end
  end

  assign fu_valid_o = fu_valid_q;
  assign fu_data_o  = fu_data_q;

  // Offer held intact until the execute unit takes it
  fu_data_held : assert property (@(posedge clk_i) disable iff (reset_i || flush_i)
    fu_valid_o && !fu_ready_i |=> fu_valid_o && $stable(fu_data_o));

endmodule

//--- design/regfile.sv
// ----------------------------------------------------------
// Register file: two async read ports, one write port, x0
// hardwired to zero
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "issue_macros.svh"

module regfile (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic [`ISSUE_REG_ADDR_BITS-1:0]   rs1_addr_i,
  input  logic [`ISSUE_REG_ADDR_BITS-1:0]   rs2_addr_i,
  output logic [`ISSUE_XLEN-1:0]            rs1_data_o,
  output logic [`ISSUE_XLEN-1:0]            rs2_data_o,
  input  logic                              we_i,
  input  logic [`ISSUE_REG_ADDR_BITS-1:0]   waddr_i,
  input  logic [`ISSUE_XLEN-1:0]            wdata_i
);

  logic [`ISSUE_XLEN-1:0] regs_q [`ISSUE_NR_REGS];

  // Reset clears the architectural state, x0 never takes a write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `ISSUE_NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Async reads, x0 forced to zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

  // Commit gating upstream keeps x0 results away from the write port
  no_x0_write : assert property (@(posedge clk_i) disable iff (reset_i)
    we_i |-> (waddr_i != '0) || (wdata_i == '0));

endmodule

//--- design/issue_stage.sv
// ----------------------------------------------------------
// Issue stage top: scoreboard, operand reader and register
// file for a single in-order issue and commit port
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_stage (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        flush_i,
  // Decode
  input  issue_pkg::decoded_instr_t   decode_instr_i,
  input  logic                        decode_valid_i,
  output logic                        decode_ack_o,
  // Execute port
  output issue_pkg::fu_data_t         fu_data_o,
  output logic                        fu_valid_o,
  input  logic                        fu_ready_i,
  // Writeback
  input  issue_pkg::writeback_t       wb_i,
  input  logic                        wb_valid_i,
  // Commit
  output issue_pkg::commit_t          commit_o,
  output logic                        commit_valid_o,
  input  logic                        commit_ack_i,
  // Status
  output logic                        sb_full_o,
  output logic                        stall_issue_o
);

  // Scoreboard to operand reader
  issue_pkg::decoded_instr_t         issue_instr;
  logic [`ISSUE_TRANS_ID_BITS-1:0]   issue_id;
  logic                              issue_valid;
  logic                              issue_ack;
  issue_pkg::fwd_t                   fwd;

  // Operand reader to register file
  logic [`ISSUE_REG_ADDR_BITS-1:0]   rs1_addr;
  logic [`ISSUE_REG_ADDR_BITS-1:0]   rs2_addr;
  logic [`ISSUE_XLEN-1:0]            rs1_data;
  logic [`ISSUE_XLEN-1:0]            rs2_data;
  logic                              rf_we;

  // Commit handshake writes back, x0 destinations skipped
  assign rf_we = commit_valid_o & commit_ack_i & (|commit_o.rd);

  // ----------------------------------------------------------
  // Instances
  // ----------------------------------------------------------
  scoreboard i_scoreboard (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .flush_i        (flush_i),
    .decode_instr_i (decode_instr_i),
    .decode_valid_i (decode_valid_i),
    .decode_ack_o   (decode_ack_o),
    .issue_instr_o  (issue_instr),
    .issue_id_o     (issue_id),
    .issue_valid_o  (issue_valid),
    .issue_ack_i    (issue_ack),
    .fwd_o          (fwd),
    .wb_i           (wb_i),
    .wb_valid_i     (wb_valid_i),
    .commit_o       (commit_o),
    .commit_valid_o (commit_valid_o),
    .commit_ack_i   (commit_ack_i),
    .sb_full_o      (sb_full_o)
  );

  issue_read_operands i_issue_read_operands (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .issue_instr_i (issue_instr),
    .issue_id_i    (issue_id),
    .issue_valid_i (issue_valid),
    .issue_ack_o   (issue_ack),
    .fwd_i         (fwd),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .fu_data_o     (fu_data_o),
    .fu_valid_o    (fu_valid_o),
    .fu_ready_i    (fu_ready_i),
    .stall_issue_o (stall_issue_o)
  );

  regfile i_regfile (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .waddr_i    (commit_o.rd),
    .wdata_i    (commit_o.data)
  );

endmodule

//--- tests/tb_issue_stage.sv
// ----------------------------------------------------------
// Issue stage testbench: random decode stream, execute unit
// responder and in-order architectural model
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "issue_macros.svh"

module tb_issue_stage;

  localparam int NUM_INSTR    = 400;
  localparam int RESET_CYCLES = 16;
  localparam int WATCHDOG_NS  = NUM_INSTR * 20 * 100;

  typedef logic [`ISSUE_REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [`ISSUE_XLEN-1:0]          data_t;

  // Program entry: instruction, expected ID and execute tag
  typedef struct packed {
    issue_pkg::decoded_instr_t       instr;
    logic [`ISSUE_TRANS_ID_BITS-1:0] id;
    data_t                           tag;
  } prog_t;

  logic                      clk            = 1'b0;
  logic                      reset_i        = 1'b1;
  logic                      flush_i        = 1'b0;
  issue_pkg::decoded_instr_t decode_instr_i = '0;
  logic                      decode_valid_i = 1'b0;
  logic                      decode_ack_o;
  issue_pkg::fu_data_t       fu_data_o;
  logic                      fu_valid_o;
  logic                      fu_ready_i     = 1'b0;
  issue_pkg::writeback_t     wb_i           = '0;
  logic                      wb_valid_i     = 1'b0;
  issue_pkg::commit_t        commit_o;
  logic                      commit_valid_o;
  logic                      commit_ack_i   = 1'b0;
  logic                      sb_full_o;
  logic                      stall_issue_o;

  // Architectural state at commit, speculative state at dispatch
  data_t                      arch_regs [`ISSUE_NR_REGS];
  data_t                      spec_regs [`ISSUE_NR_REGS];
  prog_t                      pend_q[$];
  issue_pkg::commit_t         exp_commit_q[$];
  // Execute unit: results waiting and their remaining delay
  issue_pkg::writeback_t      resp_q[$];
  int                         resp_wait_q[$];
  // Slots whose result has reached the scoreboard
  logic [`ISSUE_NR_SB_ENTRIES-1:0] wb_seen = '0;

  int                              seed     = 25;
  int                              errors   = 0;
  int                              n_accept = 0;
  int                              n_commit = 0;
  int                              cycle    = 0;
  logic [`ISSUE_TRANS_ID_BITS-1:0] alloc_id;
  logic                            held_valid   = 1'b0;
  logic                            quiet_next   = 1'b0;
  logic                            commit_stall = 1'b0;
  issue_pkg::fu_data_t             held_data;
  data_t                           cur_tag;

  issue_stage dut (
    .clk_i          (clk),
    .reset_i        (reset_i),
    .flush_i        (flush_i),
    .decode_instr_i (decode_instr_i),
    .decode_valid_i (decode_valid_i),
    .decode_ack_o   (decode_ack_o),
    .fu_data_o      (fu_data_o),
    .fu_valid_o     (fu_valid_o),
    .fu_ready_i     (fu_ready_i),
    .wb_i           (wb_i),
    .wb_valid_i     (wb_valid_i),
    .commit_o       (commit_o),
    .commit_valid_o (commit_valid_o),
    .commit_ack_i   (commit_ack_i),
    .sb_full_o      (sb_full_o),
    .stall_issue_o  (stall_issue_o)
  );

  always #50 clk = ~clk;

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Mostly a small window so producers and consumers collide often
  function automatic reg_addr_t rand_reg();
    if (rand_below(8) == 0) begin
      return reg_addr_t'(rand_below(`ISSUE_NR_REGS));
    end
    return reg_addr_t'(rand_below(8));
  endfunction

  // Operation rule of the execute unit
  function automatic data_t alu(input issue_pkg::fu_op_e op, input data_t a, input data_t b);
    case (op)
      issue_pkg::OP_ADD: return a + b;
      issue_pkg::OP_SUB: return a - b;
      issue_pkg::OP_XOR: return a ^ b;
      default:           return a & b;
    endcase
  endfunction

  // Youngest older writer of rs still waiting for its result
  function automatic logic source_blocked(input reg_addr_t rs);
    logic found;
    logic blocked;
    found   = 1'b0;
    blocked = 1'b0;
    if (rs != '0) begin
      // Parked in the dispatch register, so its result cannot be back
      if (fu_valid_o && (pend_q.size() > 0) && (pend_q[0].instr.rd == rs)) begin
        found   = 1'b1;
        blocked = 1'b1;
      end
      for (int i = exp_commit_q.size() - 1; i >= 0; i--) begin
        if (!found && (exp_commit_q[i].rd == rs)) begin
          found   = 1'b1;
          blocked = !wb_seen[exp_commit_q[i].trans_id];
        end
      end
    end
    return blocked;
  endfunction

  // Oldest instruction not yet in the dispatch register
  function automatic logic expect_stall();
    int                        idx;
    logic                      stall;
    issue_pkg::decoded_instr_t ins;
    idx   = fu_valid_o ? 1 : 0;
    stall = 1'b0;
    if (pend_q.size() > idx) begin
      ins   = pend_q[idx].instr;
      stall = source_blocked(ins.rs1) || source_blocked(ins.rs2);
    end
    return stall;
  endfunction

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic check_fu_data(input issue_pkg::fu_data_t got, input issue_pkg::fu_data_t exp,
                               input string what);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got op=%0d a=%h b=%h id=%0d", $time, what,
               got.op, got.operand_a, got.operand_b, got.trans_id);
      $display("  expected op=%0d a=%h b=%h id=%0d", exp.op, exp.operand_a,
               exp.operand_b, exp.trans_id);
    end
  endtask

  task automatic check_commit(input issue_pkg::commit_t got, input issue_pkg::commit_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: commit got rd=%0d data=%h id=%0d, expected rd=%0d data=%h id=%0d",
               $time, got.rd, got.data, got.trans_id, exp.rd, exp.data, exp.trans_id);
    end
  endtask

  task automatic check_status(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // Model, checks, execute unit and stimulus on each edge
  // ----------------------------------------------------------
  always @(posedge clk) begin
    issue_pkg::commit_t    exp_c;
    issue_pkg::fu_data_t   exp_f;
    issue_pkg::writeback_t rsp;
    prog_t                 p;
    int                    inflight;
    int                    pick;
    int                    ready_idx[$];
    logic                  do_flush;
    logic                  draining;
    cycle++;
    if (reset_i) begin
      pend_q.delete();
      exp_commit_q.delete();
      resp_q.delete();
      resp_wait_q.delete();
      alloc_id   = '0;
      wb_seen    = '0;
      held_valid = 1'b0;
      quiet_next = 1'b1;
      for (int r = 0; r < `ISSUE_NR_REGS; r++) begin
        arch_regs[r] = '0;
        spec_regs[r] = '0;
      end
      // First edge only loads the reset state
      if (cycle > 1) begin
        check_status("fu_valid_o in reset", fu_valid_o, 1'b0);
        check_status("commit_valid_o in reset", commit_valid_o, 1'b0);
        check_status("sb_full_o in reset", sb_full_o, 1'b0);
        check_status("decode_ack_o in reset", decode_ack_o, 1'b1);
      end
    end else begin
      inflight = pend_q.size() + exp_commit_q.size();
      check_status("sb_full_o", sb_full_o, inflight == `ISSUE_NR_SB_ENTRIES);
      check_status("decode_ack_o", decode_ack_o,
                   (inflight < `ISSUE_NR_SB_ENTRIES) && !flush_i);
      check_status("stall_issue_o", stall_issue_o, expect_stall());
      // Nothing left to dispatch or commit after reset or flush
      if (quiet_next) begin
        check_status("fu_valid_o after clear", fu_valid_o, 1'b0);
        check_status("commit_valid_o after clear", commit_valid_o, 1'b0);
      end
      if (held_valid) begin
        check_status("fu_valid_o while held", fu_valid_o, 1'b1);
        check_fu_data(fu_data_o, held_data, "held dispatch");
      end
      held_valid = fu_valid_o && !fu_ready_i && !flush_i;
      held_data  = fu_data_o;
      quiet_next = flush_i;
      if (flush_i) begin
        // Uncommitted work is gone, younger code sees committed state only
        pend_q.delete();
        exp_commit_q.delete();
        resp_q.delete();
        resp_wait_q.delete();
        alloc_id  = '0;
        wb_seen   = '0;
        spec_regs = arch_regs;
      end else begin
        // Result driven last edge lands in the scoreboard now
        if (wb_valid_i) begin
          wb_seen[wb_i.trans_id] = 1'b1;
        end
        if (commit_valid_o && commit_ack_i) begin
          if (exp_commit_q.size() == 0) begin
            errors++;
            $display("Commit at %0t with no dispatched instruction outstanding", $time);
          end else begin
            exp_c = exp_commit_q.pop_front();
            check_commit(commit_o, exp_c);
            if (exp_c.rd != '0) begin
              arch_regs[exp_c.rd] = exp_c.data;
            end
            n_commit++;
          end
        end
        if (fu_valid_o && fu_ready_i) begin
          if (pend_q.size() == 0) begin
            errors++;
            $display("Dispatch at %0t with no accepted instruction pending", $time);
          end else begin
            p = pend_q.pop_front();
            exp_f.op        = p.instr.op;
            exp_f.operand_a = spec_regs[p.instr.rs1];
            exp_f.operand_b = spec_regs[p.instr.rs2];
            exp_f.trans_id  = p.id;
            check_fu_data(fu_data_o, exp_f, "dispatch");
            // Tag acts like an immediate so register values move off zero
            exp_c.rd       = p.instr.rd;
            exp_c.data     = alu(exp_f.op, exp_f.operand_a, exp_f.operand_b) ^ p.tag;
            exp_c.trans_id = p.id;
            exp_commit_q.push_back(exp_c);
            if (p.instr.rd != '0) begin
              spec_regs[p.instr.rd] = exp_c.data;
            end
            // Execute unit works on the operands it actually received
            rsp.trans_id = fu_data_o.trans_id;
            rsp.data = alu(fu_data_o.op, fu_data_o.operand_a, fu_data_o.operand_b) ^ p.tag;
            resp_q.push_back(rsp);
            resp_wait_q.push_back(rand_below(6));
          end
        end
        if (decode_valid_i && decode_ack_o) begin
          p.instr = decode_instr_i;
          p.id    = alloc_id;
          p.tag   = cur_tag;
          pend_q.push_back(p);
          wb_seen[alloc_id] = 1'b0;
          alloc_id = alloc_id + 1'b1;
          n_accept++;
        end
      end

      // Execute unit returns one ripe result per cycle, any order
      ready_idx.delete();
      foreach (resp_wait_q[i]) begin
        if (resp_wait_q[i] > 0) begin
          resp_wait_q[i]--;
        end else begin
          ready_idx.push_back(i);
        end
      end
      if (ready_idx.size() > 0) begin
        pick = ready_idx[rand_below(ready_idx.size())];
        wb_i       <= resp_q[pick];
        wb_valid_i <= 1'b1;
        resp_q.delete(pick);
        resp_wait_q.delete(pick);
      end else begin
        wb_valid_i <= 1'b0;
      end

      // Stimulus for the next edge
      draining = (n_accept >= NUM_INSTR);
      do_flush = !draining && !flush_i && (rand_below(60) == 0);
      flush_i <= do_flush;
      // Long commit stalls fill the scoreboard
      if (rand_below(40) == 0) begin
        commit_stall = !commit_stall;
      end
      commit_ack_i <= !do_flush && (draining || (!commit_stall && (rand_below(4) != 0)));
      fu_ready_i   <= draining || (rand_below(4) != 0);
      // Offer held until taken
      if (!decode_valid_i || decode_ack_o) begin
        if (!draining && (rand_below(4) != 0)) begin
          decode_instr_i.op  <= issue_pkg::fu_op_e'(2'(rand_below(4)));
          decode_instr_i.rd  <= rand_reg();
          decode_instr_i.rs1 <= rand_reg();
          decode_instr_i.rs2 <= rand_reg();
          decode_valid_i     <= 1'b1;
          cur_tag = $random(seed);
        end else begin
          decode_valid_i <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Sequence and end of run
  // ----------------------------------------------------------
  initial begin
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;
    // Run until the whole stream has retired
    do begin
      @(negedge clk);
    end while (n_accept < NUM_INSTR || pend_q.size() != 0 || exp_commit_q.size() != 0);
    repeat (2) @(negedge clk);
    $display("Errors: %0d (%0d accepted, %0d committed)", errors, n_accept, n_commit);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized for every instruction taking twenty cycles
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t with %0d of %0d instructions accepted, %0d errors",
             $time, n_accept, NUM_INSTR, errors);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- compile.f
+incdir+design
design/issue_pkg.sv
design/scoreboard.sv
design/issue_read_operands.sv
design/regfile.sv
design/issue_stage.sv
tests/tb_issue_stage.sv

//--- Makefile
# Verilator build and run for the issue stage testbench

TOP := tb_issue_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

# A nonzero exit or the fail message in the log fails the run
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" sim.log; then \
	  echo "Simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
